/* common/issue_if.sv */
interface issue_if
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) ();

    logic             valid;
    alu_op_e          alu_op;
    logic             use_imm;  // Second operand from imm
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    reg_addr_t        rd;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic [XLEN-1:0]  imm;
    logic             write_en;
    logic             illegal;

    modport issue_src (
        output valid, alu_op, use_imm, rs1, rs2, rd,
        output rs1_data, rs2_data, imm, write_en, illegal
    );

    modport issue_dst (
        input valid, alu_op, use_imm, rs1, rs2, rd,
        input rs1_data, rs2_data, imm, write_en, illegal
    );

endinterface

/* common/retire_if.sv */
interface retire_if
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) ();

    logic             valid;
    reg_addr_t        rd;
    logic [XLEN-1:0]  data;
    logic             write_en;
    logic             illegal;

    // Execute also reads its own slot back for forwarding
    modport retire_src (
        output valid, rd, data, write_en, illegal
    );

    modport retire_dst (
        input valid, rd, data, write_en, illegal
    );

endinterface

/* common/rv_int_pkg.sv */
package rv_int_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int INSTR_W    = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes still decoded
    typedef enum logic [6:0] {
        OPC_REG = 7'b0110011,
        OPC_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

    localparam logic [2:0] FUNCT3_ADD = 3'b000; // add, sub, addi
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // Instruction field positions
    localparam int OPC_LSB    = 0;
    localparam int OPC_MSB    = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_B5  = 30; // Sub select in R-type

    localparam int IMM_I_LSB  = 20;
    localparam int IMM_I_MSB  = 31; // Also the sign bit

endpackage

/* sim.f */
+incdir+verification
common/rv_int_pkg.sv
common/issue_if.sv
common/retire_if.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/rv_int_core.sv
verification/tb_rv_int_core.sv

/* src/decode_stage.sv */
module decode_stage
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [INSTR_W-1:0]  in_instr,
    input  logic                advance,
    input  logic                wr_en,
    input  reg_addr_t           wr_addr,
    input  logic [XLEN-1:0]     wr_data,
    issue_if.issue_src          issue
);

    localparam int IMM_W = IMM_I_MSB - IMM_I_LSB + 1;

    opcode_e          opcode;
    logic [2:0]       funct3;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    reg_addr_t        rd;
    logic [XLEN-1:0]  imm_ext;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    alu_op_e          alu_op;
    logic             legal;
    logic             use_imm;

    assign opcode = opcode_e'(in_instr[OPC_MSB:OPC_LSB]);
    assign funct3 = in_instr[FUNCT3_MSB:FUNCT3_LSB];
    assign rs1    = in_instr[RS1_MSB:RS1_LSB];
    assign rs2    = in_instr[RS2_MSB:RS2_LSB];
    assign rd     = in_instr[RD_MSB:RD_LSB];

    assign imm_ext = {{(XLEN-IMM_W){in_instr[IMM_I_MSB]}}, in_instr[IMM_I_MSB:IMM_I_LSB]};

    always_comb begin
        alu_op  = ALU_ADD;
        legal   = 1'b1;
        use_imm = 1'b0;
        case (opcode)
            OPC_REG: begin
                case (funct3)
                    FUNCT3_ADD: alu_op = in_instr[FUNCT7_B5] ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLT: alu_op = ALU_SLT;
                    FUNCT3_OR:  alu_op = ALU_OR;
                    FUNCT3_AND: alu_op = ALU_AND;
                    default:    legal  = 1'b0;
                endcase
            end
            OPC_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    FUNCT3_ADD: alu_op = ALU_ADD; // bit 30 is immediate here
                    FUNCT3_SLT: alu_op = ALU_SLT;
                    FUNCT3_OR:  alu_op = ALU_OR;
                    FUNCT3_AND: alu_op = ALU_AND;
                    default:    legal  = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    register_file #(
        .XLEN(XLEN)
    ) u_register_file (
        .clk      (clk),
        .rst      (rst),
        .rd_addr1 (rs1),
        .rd_addr2 (rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data)
    );

    // Issue register, flags qualified by in_valid so bubbles stay inert
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue.valid    <= 1'b0;
            issue.write_en <= 1'b0;
            issue.illegal  <= 1'b0;
        end else if (advance) begin
            issue.valid    <= in_valid;
            issue.write_en <= in_valid && legal;
            issue.illegal  <= in_valid && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            issue.alu_op   <= alu_op;
            issue.use_imm  <= use_imm;
            issue.rs1      <= rs1;
            issue.rs2      <= rs2;
            issue.rd       <= rd;
            issue.rs1_data <= rs1_data;
            issue.rs2_data <= rs2_data;
            issue.imm      <= imm_ext;
        end
    end

endmodule

/* src/execute_stage.sv */
module execute_stage
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         advance,
    issue_if.issue_dst   issue,
    retire_if.retire_src retire
);

    logic             fwd1;
    logic             fwd2;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b_reg;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  result;
    logic             less;

    // Distance one, from the slot that retires on this same advance
    assign fwd1 = retire.write_en && (retire.rd != '0) && (retire.rd == issue.rs1);
    assign fwd2 = retire.write_en && (retire.rd != '0) && (retire.rd == issue.rs2);

    assign op_a     = fwd1 ? retire.data : issue.rs1_data;
    assign op_b_reg = fwd2 ? retire.data : issue.rs2_data;
    assign op_b     = issue.use_imm ? issue.imm : op_b_reg;

    assign less = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire.valid    <= 1'b0;
            retire.write_en <= 1'b0;
            retire.illegal  <= 1'b0;
        end else if (advance) begin
            retire.valid    <= issue.valid;
            retire.write_en <= issue.write_en;
            retire.illegal  <= issue.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            retire.rd   <= issue.rd;
            retire.data <= result;
        end
    end

endmodule

/* src/register_file.sv */
module register_file
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  reg_addr_t        rd_addr1,
    input  reg_addr_t        rd_addr2,
    input  logic             wr_en,
    input  reg_addr_t        wr_addr,
    input  logic [XLEN-1:0]  wr_data,
    output logic [XLEN-1:0]  rd_data1,
    output logic [XLEN-1:0]  rd_data2
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_live;
    logic            hit1;
    logic            hit2;

    // x0 is never written, so it stays at its reset value
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows through to the readers
    assign hit1 = wr_live && (wr_addr == rd_addr1);
    assign hit2 = wr_live && (wr_addr == rd_addr2);

    assign rd_data1 = hit1 ? wr_data : regs[rd_addr1];
    assign rd_data2 = hit2 ? wr_data : regs[rd_addr2];

endmodule

/* src/result_stage.sv */
module result_stage
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic             out_ready,
    retire_if.retire_dst     retire,
    output logic             advance,
    output logic             out_valid,
    output reg_addr_t        out_rd,
    output logic [XLEN-1:0]  out_data,
    output logic             out_illegal,
    output logic             wr_en,
    output reg_addr_t        wr_addr,
    output logic [XLEN-1:0]  wr_data
);

    logic take; // Retire transfer this cycle

    assign take = retire.valid && out_ready;

    // Whole pipeline moves when the slot drains or is empty
    assign advance = !retire.valid || out_ready;

    assign out_valid   = retire.valid;
    assign out_rd      = retire.rd;
    assign out_data    = retire.data;
    assign out_illegal = retire.illegal;

    assign wr_en   = take && retire.write_en;
    assign wr_addr = retire.rd;
    assign wr_data = retire.data;

endmodule

/* src/rv_int_core.sv */
module rv_int_core
    import rv_int_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [INSTR_W-1:0]  in_instr,
    output logic                out_valid,
    input  logic                out_ready,
    output reg_addr_t           out_rd,
    output logic [XLEN-1:0]     out_data,
    output logic                out_illegal
);

    logic             advance;
    logic             wr_en;
    reg_addr_t        wr_addr;
    logic [XLEN-1:0]  wr_data;

    issue_if  #(.XLEN(XLEN)) issue_bus ();
    retire_if #(.XLEN(XLEN)) retire_bus ();

    assign in_ready = advance;

    decode_stage #(
        .XLEN(XLEN)
    ) u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .advance  (advance),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .issue    (issue_bus.issue_src)
    );

    execute_stage #(
        .XLEN(XLEN)
    ) u_execute (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .issue   (issue_bus.issue_dst),
        .retire  (retire_bus.retire_src)
    );

    // Owns flow control and register write-back
    result_stage #(
        .XLEN(XLEN)
    ) u_result (
        .out_ready   (out_ready),
        .retire      (retire_bus.retire_dst),
        .advance     (advance),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_illegal (out_illegal),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

/* verification/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [6:0] OP_R      = 7'b0110011;
localparam logic [6:0] OP_I      = 7'b0010011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;
localparam logic [6:0] OP_STORE  = 7'b0100011;
localparam logic [6:0] OP_BRANCH = 7'b1100011;

localparam logic [2:0] F_ADD = 3'b000; // add, sub, addi
localparam logic [2:0] F_SLT = 3'b010;
localparam logic [2:0] F_OR  = 3'b110;
localparam logic [2:0] F_AND = 3'b111;

logic [31:0] ref_regs [32];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];
logic        exp_illegal [$];

function automatic logic [31:0] r_instr(logic sub, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, OP_R};
endfunction

function automatic logic [31:0] i_instr(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_I};
endfunction

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
endfunction

// Applies one instruction in program order and queues its expected retire
function automatic void predict(logic [31:0] instr);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ok;
    opc = instr[6:0];
    f3  = instr[14:12];
    rd  = instr[11:7];
    a   = ref_regs[instr[19:15]];
    b   = (opc == OP_I) ? {{20{instr[31]}}, instr[31:20]} : ref_regs[instr[24:20]];
    ok  = (opc == OP_R) || (opc == OP_I);
    res = '0;
    case (f3)
        F_ADD:   res = (opc == OP_R && instr[30]) ? a - b : a + b;
        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F_OR:    res = a | b;
        F_AND:   res = a & b;
        default: ok = 1'b0;
    endcase
    exp_rd.push_back(rd);
    exp_data.push_back(res);
    exp_illegal.push_back(!ok);
    if (ok && rd != 5'd0) begin
        ref_regs[rd] = res; // x0 keeps zero
    end
endfunction

`endif

/* verification/tb_rv_int_core.sv */
module tb_rv_int_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ALU        = 15;
    localparam int N_FWD        = 10;
    localparam int N_BP         = 24;
    localparam int N_X0         = 12;
    localparam int TOTAL_INSTRS = N_ALU + N_FWD + N_BP + N_X0;
    localparam int CYCLE_LIMIT  = 4 * TOTAL_INSTRS + 200;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic        out_valid;
    logic        out_ready;
    logic [4:0]  out_rd;
    logic [31:0] out_data;
    logic        out_illegal;

    logic        stall_mode;
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    int          stall_cycles;
    int          cycle_count;
    string       cur_test;

    `include "tb_ref_model.svh"

    rv_int_core #(
        .XLEN(32)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_illegal (out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h",
                     cur_test, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            $display("Test failures found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Holds the instruction until the core takes it
    task automatic send(logic [31:0] instr, int gap);
        in_valid = 1'b1;
        in_instr = instr;
        predict(instr);
        do begin
            @(posedge clk);
        end while (!in_ready);
        @(negedge clk);
        in_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic drain();
        while (exp_rd.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_retire();
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ill;
        check_true(exp_rd.size() > 0, "a result retired with no instruction outstanding");
        rd   = exp_rd.pop_front();
        data = exp_data.pop_front();
        ill  = exp_illegal.pop_front();
        check_value("out_illegal", 32'(ill), 32'(out_illegal));
        if (!ill) begin
            check_value("out_rd", 32'(rd), 32'(out_rd));
            check_value("out_data", data, out_data);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && !out_ready) begin
                stall_cycles++;
                check_true(!in_ready, "in_ready was high while the retire port was stalled");
            end
            if (out_valid && out_ready) begin
                compare_retire();
            end
        end
    end

    always @(negedge clk) begin
        if (stall_mode) begin
            rnd = lcg_next();
            out_ready = rnd[20];
        end else begin
            out_ready = 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $fatal(1, "Timeout");
    end

    task automatic test_reset();
        cur_test = "test_reset";
        check_true(out_valid === 1'b0, "out_valid was not low after reset");
        check_true(in_ready === 1'b1, "in_ready was not high after reset");
    endtask

    task automatic test_alu_ops();
        cur_test = "test_alu_ops";
        send(i_instr(F_ADD, 5'd1, 5'd0, 12'd100), 2);
        send(i_instr(F_ADD, 5'd2, 5'd0, 12'hfdb), 2); // -37
        send(i_instr(F_ADD, 5'd3, 5'd0, 12'h800), 2); // Most negative immediate
        send(i_instr(F_ADD, 5'd4, 5'd0, 12'h7ff), 2);
        send(r_instr(1'b0, F_ADD, 5'd5, 5'd1, 5'd2), 2);
        send(r_instr(1'b1, F_ADD, 5'd6, 5'd2, 5'd1), 2);
        send(r_instr(1'b0, F_SLT, 5'd7, 5'd2, 5'd1), 2); // -37 < 100 only when signed
        send(r_instr(1'b0, F_SLT, 5'd8, 5'd1, 5'd2), 2);
        send(r_instr(1'b0, F_OR, 5'd9, 5'd3, 5'd4), 2);
        send(r_instr(1'b0, F_AND, 5'd10, 5'd1, 5'd2), 2);
        send(i_instr(F_ADD, 5'd11, 5'd2, 12'hf9c), 2); // -100
        send(i_instr(F_SLT, 5'd12, 5'd1, 12'hffb), 2);
        send(i_instr(F_SLT, 5'd13, 5'd3, 12'd5), 2);
        send(i_instr(F_OR, 5'd14, 5'd1, 12'hf00), 2);
        send(i_instr(F_AND, 5'd15, 5'd2, 12'h7f0), 2);
        drain();
    endtask

    task automatic test_forwarding();
        cur_test = "test_forwarding";
        send(i_instr(F_ADD, 5'd1, 5'd0, 12'd5), 0);
        send(r_instr(1'b0, F_ADD, 5'd2, 5'd1, 5'd1), 0); // Distance one on both sides
        send(r_instr(1'b0, F_ADD, 5'd3, 5'd2, 5'd1), 0); // x1 at distance two
        send(r_instr(1'b1, F_ADD, 5'd4, 5'd3, 5'd2), 0);
        send(r_instr(1'b0, F_SLT, 5'd5, 5'd4, 5'd3), 0);
        send(r_instr(1'b0, F_OR, 5'd6, 5'd5, 5'd4), 0);
        send(i_instr(F_ADD, 5'd6, 5'd6, 12'hfff), 0);
        send(r_instr(1'b0, F_AND, 5'd7, 5'd6, 5'd3), 0);
        send(i_instr(F_ADD, 5'd1, 5'd7, 12'd3), 0);
        send(r_instr(1'b0, F_ADD, 5'd1, 5'd1, 5'd1), 0);
        drain();
    endtask

    task automatic test_backpressure();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        cur_test     = "test_backpressure";
        stall_cycles = 0;
        stall_mode   = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            rd  = 5'(20 + i % 7);
            rs1 = 5'(20 + (i + 6) % 7); // Previous destination
            rs2 = 5'(20 + (i + 5) % 7);
            imm = 12'(i * 53 - 400);
            case (i % 6)
                0:       send(r_instr(1'b0, F_ADD, rd, rs1, rs2), 0);
                1:       send(r_instr(1'b1, F_ADD, rd, rs1, rs2), 0);
                2:       send(i_instr(F_OR, rd, rs1, imm), 0);
                3:       send(r_instr(1'b0, F_SLT, rd, rs1, rs2), 0);
                4:       send(i_instr(F_ADD, rd, rs1, imm), 0);
                default: send(r_instr(1'b0, F_AND, rd, rs1, rs2), 0);
            endcase
        end
        drain();
        stall_mode = 1'b0;
        check_true(stall_cycles > 0, "out_ready never stalled a valid result");
    endtask

    task automatic test_x0_and_illegal();
        cur_test = "test_x0_and_illegal";
        send(i_instr(F_ADD, 5'd0, 5'd0, 12'd55), 0);
        send(r_instr(1'b0, F_ADD, 5'd16, 5'd0, 5'd0), 0); // x0 read right behind its write
        send(r_instr(1'b0, F_ADD, 5'd0, 5'd1, 5'd2), 0);
        send(i_instr(F_ADD, 5'd17, 5'd0, 12'd7), 0);
        send({12'd4, 5'd1, 3'b010, 5'd5, OP_LOAD}, 0);
        send({7'd0, 5'd2, 5'd1, 3'b010, 5'd6, OP_STORE}, 0);
        send({7'd0, 5'd2, 5'd1, 3'b000, 5'd8, OP_BRANCH}, 0);
        send(r_instr(1'b0, 3'b001, 5'd9, 5'd1, 5'd2), 0); // sll, outside the subset
        send(i_instr(F_ADD, 5'd27, 5'd5, 12'd0), 0);
        send(i_instr(F_ADD, 5'd28, 5'd6, 12'd0), 0);
        send(i_instr(F_ADD, 5'd29, 5'd8, 12'd0), 0);
        send(i_instr(F_ADD, 5'd30, 5'd9, 12'd0), 0);
        drain();
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        out_ready    = 1'b1;
        stall_mode   = 1'b0;
        lcg_state    = 32'd97938;
        stall_cycles = 0;
        cur_test     = "reset";
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_alu_ops();
        test_forwarding();
        test_backpressure();
        test_x0_and_illegal();
        $display("All tests passed!");
        $finish;
    end

endmodule
